// File: carfield_lite_pkg.sv
package carfield_lite_pkg;

    // Byte addressed host register request
    typedef struct packed {
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        error;
    } reg_rsp_t;

    // Request destination
    typedef enum logic [1:0] {
        TGT_CFG,
        TGT_MEM,
        TGT_NONE
    } target_e;

    typedef struct packed {
        reg_req_t req;
        target_e  target;
    } routed_req_t;

    // Address map
    localparam logic [15:0] CfgBase = 16'h0000;
    localparam logic [15:0] CfgSpan = 16'h0100;
    localparam logic [15:0] MemBase = 16'h1000;

    // Configuration register offsets
    localparam logic [7:0] CfgOffBoot  = 8'h00;
    localparam logic [7:0] CfgOffPadOe = 8'h04;
    localparam logic [7:0] CfgOffId    = 8'h08;

    localparam logic [31:0] ChipId = 32'hCA4F1E01;

    // Pad output enables are active high inside the chip
    typedef struct packed {
        logic       i2c_sda;
        logic       i2c_scl;
        logic       spim_sck;
        logic [1:0] spim_csb;
        logic [3:0] spim_sd;
    } pad_oe_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_o <= data_i;
    end

endmodule

// File: req_route.sv
`timescale 1ns/1ps

module req_route #(
    parameter int unsigned MemWords = 256
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_valid_i,
    input  carfield_lite_pkg::reg_req_t    req_i,
    output logic                          routed_valid_o,
    output carfield_lite_pkg::routed_req_t routed_o
);

    import carfield_lite_pkg::*;

    // End of memory region is one bit wider so the top word never wraps
    localparam logic [16:0] MemEnd = {1'b0, MemBase} + 17'(MemWords * 4);
    localparam logic [15:0] CfgEnd = CfgBase + CfgSpan;

    logic        in_cfg;
    logic        in_mem;
    routed_req_t tagged_req;

    assign in_cfg = (req_i.addr >= CfgBase) && (req_i.addr < CfgEnd);
    assign in_mem = (req_i.addr >= MemBase) && ({1'b0, req_i.addr} < MemEnd);

    always_comb begin
        tagged_req.req = req_i;
        if (in_cfg) begin
            tagged_req.target = TGT_CFG;
        end else if (in_mem) begin
            tagged_req.target = TGT_MEM;
        end else begin
            tagged_req.target = TGT_NONE;
        end
    end

    pipe_reg #(
        .payload_t ( routed_req_t )
    ) route_stage_inst (
        .clk_i   ( clk_i          ),
        .reset_i ( reset_i        ),
        .valid_i ( req_valid_i    ),
        .data_i  ( tagged_req     ),
        .valid_o ( routed_valid_o ),
        .data_o  ( routed_o       )
    );

endmodule

// File: soc_cfg_regs.sv
`timescale 1ns/1ps

module soc_cfg_regs #(
    parameter logic [31:0] BootAddrDefault = 32'h0000_1000
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          routed_valid_i,
    input  carfield_lite_pkg::routed_req_t routed_i,
    output carfield_lite_pkg::reg_rsp_t    cfg_rsp_o,
    output logic [31:0]                   boot_addr_o,
    output logic                          i2c_sda_en_no,
    output logic                          i2c_scl_en_no,
    output logic                          spim_sck_en_no,
    output logic [1:0]                    spim_csb_en_no,
    output logic [3:0]                    spim_sd_en_no
);

    import carfield_lite_pkg::*;

    logic        access;
    logic        is_write;
    logic [7:0]  offset;
    logic        boot_we;
    logic        pad_we;
    logic [31:0] boot_addr_q;
    pad_oe_t     pad_oe_q;
    reg_rsp_t    rsp_d;

    assign access   = routed_valid_i && (routed_i.target == TGT_CFG);
    assign is_write = routed_i.req.write;

    // Word aligned offset with byte lanes ignored
    assign offset = {routed_i.req.addr[7:2], 2'b00};

    assign boot_we = access && is_write && (offset == CfgOffBoot);
    assign pad_we  = access && is_write && (offset == CfgOffPadOe);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            boot_addr_q <= BootAddrDefault;
            pad_oe_q    <= '0;
        end else begin
            if (boot_we) begin
                boot_addr_q <= routed_i.req.wdata;
            end
            if (pad_we) begin
                pad_oe_q <= pad_oe_t'(routed_i.req.wdata[$bits(pad_oe_t)-1:0]);
            end
        end
    end

    always_comb begin
        rsp_d.rdata = '0;
        rsp_d.error = 1'b0;
        case (offset)
            CfgOffBoot: begin
                if (!is_write) begin
                    rsp_d.rdata = boot_addr_q;
                end
            end
            CfgOffPadOe: begin
                if (!is_write) begin
                    rsp_d.rdata = {23'd0, pad_oe_q};
                end
            end
            CfgOffId: begin
                // Identity is read only
                if (is_write) begin
                    rsp_d.error = 1'b1;
                end else begin
                    rsp_d.rdata = ChipId;
                end
            end
            default: rsp_d.error = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_rsp_o <= '0;
        end else if (access) begin
            cfg_rsp_o <= rsp_d;
        end
    end

    assign boot_addr_o = boot_addr_q;

    // Pads want active low enables
    assign i2c_sda_en_no  = ~pad_oe_q.i2c_sda;
    assign i2c_scl_en_no  = ~pad_oe_q.i2c_scl;
    assign spim_sck_en_no = ~pad_oe_q.spim_sck;
    assign spim_csb_en_no = ~pad_oe_q.spim_csb;
    assign spim_sd_en_no  = ~pad_oe_q.spim_sd;

endmodule

// File: hyper_mem.sv
`timescale 1ns/1ps

module hyper_mem #(
    parameter int unsigned MemWords = 256
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          routed_valid_i,
    input  carfield_lite_pkg::routed_req_t routed_i,
    output carfield_lite_pkg::reg_rsp_t    mem_rsp_o
);

    import carfield_lite_pkg::*;

    localparam int unsigned IdxW = $clog2(MemWords);

    logic [31:0]     mem_q [MemWords];
    logic            access;
    logic [15:0]     word_off;
    logic [IdxW-1:0] word_idx;

    assign access   = routed_valid_i && (routed_i.target == TGT_MEM);
    assign word_off = routed_i.req.addr - MemBase;

    // Drop the byte offset
    assign word_idx = word_off[IdxW+1:2];

    always_ff @(posedge clk_i) begin
        if (access && routed_i.req.write) begin
            mem_q[word_idx] <= routed_i.req.wdata;
        end
    end

    // Writes answer with zero data, reads with the stored word
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_rsp_o <= '0;
        end else if (access) begin
            mem_rsp_o.error <= 1'b0;
            if (routed_i.req.write) begin
                mem_rsp_o.rdata <= '0;
            end else begin
                mem_rsp_o.rdata <= mem_q[word_idx];
            end
        end
    end

endmodule

// File: rsp_merge.sv
`timescale 1ns/1ps

module rsp_merge (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          routed_valid_i,
    input  carfield_lite_pkg::routed_req_t routed_i,
    input  carfield_lite_pkg::reg_rsp_t    cfg_rsp_i,
    input  carfield_lite_pkg::reg_rsp_t    mem_rsp_i,
    output logic                          rsp_valid_o,
    output carfield_lite_pkg::reg_rsp_t    rsp_o
);

    import carfield_lite_pkg::*;

    logic     valid_q;
    target_e  target_q;
    reg_rsp_t sel_rsp;

    // Tag follows the request through the target stage
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q  <= 1'b0;
            target_q <= TGT_NONE;
        end else begin
            valid_q  <= routed_valid_i;
            target_q <= routed_i.target;
        end
    end

    always_comb begin
        case (target_q)
            TGT_CFG: sel_rsp = cfg_rsp_i;
            TGT_MEM: sel_rsp = mem_rsp_i;
            default: begin
                // Unmapped address
                sel_rsp.rdata = '0;
                sel_rsp.error = 1'b1;
            end
        endcase
    end

    pipe_reg #(
        .payload_t ( reg_rsp_t )
    ) rsp_stage_inst (
        .clk_i   ( clk_i       ),
        .reset_i ( reset_i     ),
        .valid_i ( valid_q     ),
        .data_i  ( sel_rsp     ),
        .valid_o ( rsp_valid_o ),
        .data_o  ( rsp_o       )
    );

endmodule

// File: carfield_lite.sv
`timescale 1ns/1ps

module carfield_lite #(
    parameter int unsigned MemWords        = 256,
    parameter logic [31:0] BootAddrDefault = 32'h0000_1000
) (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Host register port
    input  logic                       req_valid_i,
    input  carfield_lite_pkg::reg_req_t req_i,
    output logic                       rsp_valid_o,
    output carfield_lite_pkg::reg_rsp_t rsp_o,

    output logic [31:0]                boot_addr_o,

    // Active low pad enables
    output logic                       i2c_sda_en_no,
    output logic                       i2c_scl_en_no,
    output logic                       spim_sck_en_no,
    output logic [1:0]                 spim_csb_en_no,
    output logic [3:0]                 spim_sd_en_no
);

    import carfield_lite_pkg::*;

    logic        routed_valid;
    routed_req_t routed;
    reg_rsp_t    cfg_rsp;
    reg_rsp_t    mem_rsp;

    req_route #(
        .MemWords ( MemWords )
    ) req_route_inst (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .req_valid_i    ( req_valid_i  ),
        .req_i          ( req_i        ),
        .routed_valid_o ( routed_valid ),
        .routed_o       ( routed       )
    );

    soc_cfg_regs #(
        .BootAddrDefault ( BootAddrDefault )
    ) soc_cfg_regs_inst (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .routed_valid_i ( routed_valid   ),
        .routed_i       ( routed         ),
        .cfg_rsp_o      ( cfg_rsp        ),
        .boot_addr_o    ( boot_addr_o    ),
        .i2c_sda_en_no  ( i2c_sda_en_no  ),
        .i2c_scl_en_no  ( i2c_scl_en_no  ),
        .spim_sck_en_no ( spim_sck_en_no ),
        .spim_csb_en_no ( spim_csb_en_no ),
        .spim_sd_en_no  ( spim_sd_en_no  )
    );

    // Stands in for the external DRAM path
    hyper_mem #(
        .MemWords ( MemWords )
    ) hyper_mem_inst (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .routed_valid_i ( routed_valid ),
        .routed_i       ( routed       ),
        .mem_rsp_o      ( mem_rsp      )
    );

    rsp_merge rsp_merge_inst (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .routed_valid_i ( routed_valid ),
        .routed_i       ( routed       ),
        .cfg_rsp_i      ( cfg_rsp      ),
        .mem_rsp_i      ( mem_rsp      ),
        .rsp_valid_o    ( rsp_valid_o  ),
        .rsp_o          ( rsp_o        )
    );

endmodule

// File: carfield_lite_properties.sv
`timescale 1ns/1ps

module carfield_lite_properties (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        req_valid_i,
    input logic                        rsp_valid_o,
    input carfield_lite_pkg::reg_rsp_t rsp_o,
    input logic                        i2c_sda_en_no,
    input logic                        i2c_scl_en_no,
    input logic                        spim_sck_en_no,
    input logic [1:0]                  spim_csb_en_no,
    input logic [3:0]                  spim_sd_en_no
);

    int fail_count = 0;

    // Fixed three cycle latency in both directions
    req_to_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> ##3 rsp_valid_o)
        else begin
            $error("request not answered after 3 cycles");
            fail_count++;
        end

    rsp_from_req: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> $past(req_valid_i, 3))
        else begin
            $error("response without a request 3 cycles earlier");
            fail_count++;
        end

    rsp_known: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> !$isunknown(rsp_o))
        else begin
            $error("rsp_o has unknown bits while valid");
            fail_count++;
        end

    pads_off_after_reset: assert property (@(posedge clk_i)
        $fell(reset_i) |-> &{i2c_sda_en_no, i2c_scl_en_no, spim_sck_en_no,
                              spim_csb_en_no, spim_sd_en_no})
        else begin
            $error("pad enables active right after reset");
            fail_count++;
        end

endmodule

bind carfield_lite carfield_lite_properties carfield_lite_props_inst (.*);

// File: tb_carfield_lite.sv
`timescale 1ns/1ps

module tb_carfield_lite;

    import carfield_lite_pkg::*;

    localparam int          ClkPeriod    = 40;
    localparam int          ResetCycles  = 16;
    localparam int          MemWordsTb   = 256;
    localparam logic [31:0] BootDefault  = 32'h0000_1000;
    localparam int          DrainLimit   = 20;
    // Requests of all five tests and the six drains between them
    localparam int          ReqCycles    = 83;
    localparam int          DrainCount   = 6;
    localparam int          TestCycles   = ReqCycles + DrainCount * (DrainLimit + 1);
    localparam int          MarginCycles = 50;

    logic        clk_i;
    logic        reset_i;
    logic        req_valid_i;
    reg_req_t    req_i;
    logic        rsp_valid_o;
    reg_rsp_t    rsp_o;
    logic [31:0] boot_addr_o;
    logic        i2c_sda_en_no;
    logic        i2c_scl_en_no;
    logic        spim_sck_en_no;
    logic [1:0]  spim_csb_en_no;
    logic [3:0]  spim_sd_en_no;

    reg_rsp_t    exp_q[$];
    logic [31:0] boot_m;
    pad_oe_t     pad_oe_m;
    logic [31:0] mem_m[int];
    int          mismatch_count;
    int          other_count;
    integer      seed;

    carfield_lite carfield_lite_inst (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .req_valid_i    ( req_valid_i    ),
        .req_i          ( req_i          ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_o          ( rsp_o          ),
        .boot_addr_o    ( boot_addr_o    ),
        .i2c_sda_en_no  ( i2c_sda_en_no  ),
        .i2c_scl_en_no  ( i2c_scl_en_no  ),
        .spim_sck_en_no ( spim_sck_en_no ),
        .spim_csb_en_no ( spim_csb_en_no ),
        .spim_sd_en_no  ( spim_sd_en_no  )
    );

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    task automatic check_rsp(input reg_rsp_t got, input reg_rsp_t exp);
        if (got !== exp) begin
            $display("mismatch rsp_o: got rdata=%h error=%h, expected rdata=%h error=%h",
                     got.rdata, got.error, exp.rdata, exp.error);
            mismatch_count++;
        end
    endtask

    task automatic check_boot(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch boot_addr_o: got %h expected %h", got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_pad(input pad_oe_t exp);
        pad_oe_t got;
        got = pad_oe_t'(~{i2c_sda_en_no, i2c_scl_en_no, spim_sck_en_no,
                          spim_csb_en_no, spim_sd_en_no});
        if (got !== exp) begin
            $display("mismatch pad enables (inverted _en_no): got %h expected %h", got, exp);
            mismatch_count++;
        end
    endtask

    // Reference model of the address map updated in request order
    task automatic predict_rsp(input logic write, input logic [15:0] addr,
                               input logic [31:0] wdata, output reg_rsp_t exp);
        logic [7:0] off;
        int         idx;
        exp.rdata = '0;
        exp.error = 1'b0;
        off = {addr[7:2], 2'b00};
        if (addr >= CfgBase && addr < CfgBase + CfgSpan) begin
            if (off == CfgOffBoot) begin
                if (write) boot_m = wdata;
                else exp.rdata = boot_m;
            end else if (off == CfgOffPadOe) begin
                if (write) pad_oe_m = pad_oe_t'(wdata[8:0]);
                else exp.rdata = 32'(pad_oe_m);
            end else if (off == CfgOffId) begin
                if (write) exp.error = 1'b1;
                else exp.rdata = ChipId;
            end else begin
                exp.error = 1'b1;
            end
        end else if (addr >= MemBase && addr < MemBase + MemWordsTb * 4) begin
            idx = int'(addr - MemBase) >> 2;
            if (write) mem_m[idx] = wdata;
            else exp.rdata = mem_m[idx];
        end else begin
            exp.error = 1'b1;
        end
    endtask

    task automatic send_req(input logic write, input logic [15:0] addr, input logic [31:0] wdata);
        reg_rsp_t exp;
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_i.write = write;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        predict_rsp(write, addr, wdata, exp);
        exp_q.push_back(exp);
    endtask

    // Stop issuing and wait for every outstanding response
    task automatic drain;
        int n;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < DrainLimit) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            other_count++;
            exp_q.delete();
        end
    endtask

    always @(negedge clk_i) begin
        if (!reset_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("rsp_valid_o was raised with no request outstanding");
                other_count++;
            end else begin
                check_rsp(rsp_o, exp_q.pop_front());
            end
        end
    end

    task automatic read_reset_values;
        check_pad('0);
        check_boot(boot_addr_o, BootDefault);
        send_req(1'b0, 16'h0000, '0);
        send_req(1'b0, 16'h0004, '0);
        send_req(1'b0, 16'h0008, '0);
        drain();
    endtask

    task automatic write_cfg_regs;
        send_req(1'b1, 16'h0000, 32'h2000_0400);
        send_req(1'b1, 16'h0004, 32'h0000_01A5);
        drain();
        check_boot(boot_addr_o, 32'h2000_0400);
        check_pad(pad_oe_t'(9'h1A5));
        send_req(1'b0, 16'h0000, '0);
        send_req(1'b0, 16'h0006, '0);
        drain();
    endtask

    task automatic stream_memory;
        logic [15:0] addrs[32];
        int          idx;
        for (int i = 0; i < 32; i++) begin
            idx = $random(seed) & (MemWordsTb - 1);
            addrs[i] = MemBase + 16'(idx * 4) + 16'($random(seed) & 3);
            send_req(1'b1, addrs[i], $random(seed));
        end
        for (int i = 0; i < 32; i++) begin
            send_req(1'b0, addrs[i], '0);
        end
        drain();
    endtask

    task automatic probe_decode_errors;
        send_req(1'b0, 16'h0200, '0);
        send_req(1'b0, 16'h1400, '0);
        send_req(1'b1, 16'h8000, 32'h1234_5678);
        send_req(1'b0, 16'h000C, '0);
        drain();
    endtask

    task automatic mix_identity_targets;
        send_req(1'b1, 16'h0008, 32'hFFFF_FFFF);
        send_req(1'b0, 16'h0008, '0);
        send_req(1'b1, 16'h13FC, 32'hA5A5_0F0F);
        send_req(1'b0, 16'h0004, '0);
        send_req(1'b0, 16'h13FC, '0);
        send_req(1'b0, 16'h0100, '0);
        send_req(1'b1, 16'h0000, 32'h0000_2000);
        send_req(1'b0, 16'h0000, '0);
        drain();
    endtask

    initial begin
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        req_valid_i    = 1'b0;
        req_i          = '0;
        boot_m         = BootDefault;
        pad_oe_m       = '0;
        mismatch_count = 0;
        other_count    = 0;
        seed           = 12;
        repeat (ResetCycles) @(negedge clk_i);
        reset_i = 1'b0;
        read_reset_values();
        write_cfg_regs();
        stream_memory();
        probe_decode_errors();
        mix_identity_targets();
        $display("errors: mismatches=%0d other=%0d assertions=%0d", mismatch_count,
                 other_count, carfield_lite_inst.carfield_lite_props_inst.fail_count);
        if (mismatch_count == 0 && other_count == 0 &&
            carfield_lite_inst.carfield_lite_props_inst.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(ClkPeriod * (ResetCycles + TestCycles + MarginCycles));
        $display("watchdog expired before the tests completed");
        $display("errors: mismatches=%0d other=%0d assertions=%0d", mismatch_count,
                 other_count + 1, carfield_lite_inst.carfield_lite_props_inst.fail_count);
        $display("Test failed");
        $finish;
    end

endmodule

// File: project.f
carfield_lite_pkg.sv
pipe_reg.sv
req_route.sv
soc_cfg_regs.sv
hyper_mem.sv
rsp_merge.sv
carfield_lite.sv
carfield_lite_properties.sv
tb_carfield_lite.sv
